// File: src/pipe_pkg.sv
// Shared definitions for the three-stage ID/EX/WB integer pipeline.
// Holds widths, opcodes, the instruction word views, operand selects
// and the stage structs that travel between the pipeline modules.
package pipe_pkg;

	//////////////////////////////
	// Widths
	//////////////////////////////

	localparam int DATA_W   = 32;
	localparam int REG_AW   = 4;
	localparam int IMM_W    = 16;
	localparam int OP_W     = 4;
	localparam int NUM_REGS = 1 << REG_AW;

	// Opcodes, any other value executes as ADD
	typedef enum logic [OP_W-1:0] {
		OP_ADD  = 4'd0,
		OP_SUB  = 4'd1,
		OP_AND  = 4'd2,
		OP_OR   = 4'd3,
		OP_XOR  = 4'd4,
		OP_ADDI = 4'd5,
		OP_ORI  = 4'd6,
		OP_XORI = 4'd7
	} opcode_e;

	//////////////////////////////
	// Instruction word
	//////////////////////////////

	// Register-register view
	typedef struct packed {
		logic [OP_W-1:0]   opcode;
		logic [REG_AW-1:0] rd;
		logic [REG_AW-1:0] ra;
		logic [REG_AW-1:0] rb;
		logic [15:0]       unused;
	} instr_r_t;

	// Register-immediate view, imm sits in the low half
	typedef struct packed {
		logic [OP_W-1:0]   opcode;
		logic [REG_AW-1:0] rd;
		logic [REG_AW-1:0] ra;
		logic [3:0]        unused;
		logic [IMM_W-1:0]  imm;
	} instr_i_t;

	// Same 32-bit word, opcode picks the view
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

	// Operand sources, IMM only meaningful for operand B
	typedef enum logic [1:0] {
		SEL_RF      = 2'd0,
		SEL_IMM     = 2'd1,
		SEL_EX_FORW = 2'd2,
		SEL_WB_FORW = 2'd3
	} sel_e;

	//////////////////////////////
	// Stage structs
	//////////////////////////////

	typedef struct packed {
		logic              valid;
		opcode_e           op;
		logic [REG_AW-1:0] rd;
	} ex_ctrl_t;

	typedef struct packed {
		logic              valid;
		logic [REG_AW-1:0] rd;
		logic [DATA_W-1:0] data;
	} wb_t;

endpackage

// File: src/pipe_ctrl.sv
// Pipeline control: holds the ID-stage instruction and decodes it.
// Drives register-file read addresses, operand source selects and the
// sign-extended immediate, turns the stall level into the shared freeze,
// and passes the EX-stage control struct along.
`timescale 1ns/1ps

module pipe_ctrl (
	input  logic                         clk,
	input  logic                         arst_n,
	input  pipe_pkg::instr_u             instr,
	input  logic                         instr_valid,
	input  logic                         stall,
	input  pipe_pkg::wb_t                wb_st,
	output logic [pipe_pkg::REG_AW-1:0] ra_addr,
	output logic [pipe_pkg::REG_AW-1:0] rb_addr,
	output pipe_pkg::sel_e               sel_a,
	output pipe_pkg::sel_e               sel_b,
	output logic [pipe_pkg::DATA_W-1:0] simm,
	output logic                         freeze,
	output pipe_pkg::ex_ctrl_t           ex_ctrl
);
	import pipe_pkg::*;

	// ID stage contents
	instr_u  id_instr;
	logic    id_valid;
	opcode_e id_op;
	logic    id_imm_op;

	// Pick the newest producer of a source register
	function automatic sel_e fwd_sel(
		input logic [REG_AW-1:0] src,
		input logic              ex_valid,
		input logic [REG_AW-1:0] ex_rd,
		input logic              wb_valid,
		input logic [REG_AW-1:0] wb_rd
	);
		sel_e sel;
		sel = SEL_RF;
		if (ex_valid && (ex_rd == src))
			sel = SEL_EX_FORW;
		else if (wb_valid && (wb_rd == src))
			sel = SEL_WB_FORW;
		return sel;
	endfunction

	// ID and EX freeze together on stall
	assign freeze = stall;

	//////////////////////////////
	// ID stage register
	//////////////////////////////

	// Accept only while not frozen, instr_valid ignored under stall
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_valid <= 1'b0;
			id_instr <= '0;
		end else if (!freeze) begin
			id_valid <= instr_valid;
			if (instr_valid)
				id_instr <= instr;
		end
	end

	//////////////////////////////
	// Decode
	//////////////////////////////

	assign id_op = opcode_e'(id_instr.r.opcode);

	always_comb begin
		id_imm_op = (id_op inside {OP_ADDI, OP_ORI, OP_XORI});
	end

	// Source fields sit at the same place in both views
	assign ra_addr = id_instr.r.ra;
	assign rb_addr = id_instr.r.rb;

	// Sign extend the I-format immediate
	assign simm = {{(DATA_W-IMM_W){id_instr.i.imm[IMM_W-1]}}, id_instr.i.imm};

	// Recomputed every cycle, so a held instruction tracks the stages
	always_comb begin
		sel_a = fwd_sel(ra_addr, ex_ctrl.valid, ex_ctrl.rd, wb_st.valid, wb_st.rd);
		if (id_imm_op)
			sel_b = SEL_IMM;
		else
			sel_b = fwd_sel(rb_addr, ex_ctrl.valid, ex_ctrl.rd, wb_st.valid, wb_st.rd);
	end

	//////////////////////////////
	// EX stage control
	//////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_ctrl <= '0;
		end else if (!freeze) begin
			ex_ctrl.valid <= id_valid;
			ex_ctrl.op    <= id_op;
			ex_ctrl.rd    <= id_instr.r.rd;
		end
	end

endmodule

// File: src/reg_file.sv
// General purpose register file, 16 x 32 bits.
// Two asynchronous read ports for the ID stage and one write port
// fed from the WB stage entry.
`timescale 1ns/1ps

module reg_file (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic [pipe_pkg::REG_AW-1:0] ra_addr,
	input  logic [pipe_pkg::REG_AW-1:0] rb_addr,
	input  pipe_pkg::wb_t                wb_st,
	output logic [pipe_pkg::DATA_W-1:0] rf_dataa,
	output logic [pipe_pkg::DATA_W-1:0] rf_datab
);
	import pipe_pkg::*;

	// Register storage
	logic [DATA_W-1:0] regs [NUM_REGS];

	//////////////////////////////
	// Write port
	//////////////////////////////

	// All registers come out of reset at zero
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wb_st.valid) begin
			regs[wb_st.rd] <= wb_st.data;
		end
	end

	//////////////////////////////
	// Read ports
	//////////////////////////////

	// Same-cycle write is covered by WB forwarding, not here
	assign rf_dataa = regs[ra_addr];
	assign rf_datab = regs[rb_addr];

endmodule

// File: src/operand_mux.sv
// Operand stage between ID and EX.
// Chooses each ALU operand from the register file, the EX result,
// the WB result or the immediate, and registers it for EX.
// The operand registers hold while the pipeline is frozen.
`timescale 1ns/1ps

module operand_mux (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         freeze,
	input  logic [pipe_pkg::DATA_W-1:0] rf_dataa,
	input  logic [pipe_pkg::DATA_W-1:0] rf_datab,
	input  logic [pipe_pkg::DATA_W-1:0] ex_forw,
	input  logic [pipe_pkg::DATA_W-1:0] wb_forw,
	input  logic [pipe_pkg::DATA_W-1:0] simm,
	input  pipe_pkg::sel_e               sel_a,
	input  pipe_pkg::sel_e               sel_b,
	output logic [pipe_pkg::DATA_W-1:0] operand_a,
	output logic [pipe_pkg::DATA_W-1:0] operand_b
);
	import pipe_pkg::*;

	// Selected values ahead of the registers
	logic [DATA_W-1:0] muxed_a;
	logic [DATA_W-1:0] muxed_b;

	//////////////////////////////
	// Source selection
	//////////////////////////////

	// Operand A has no immediate, SEL_IMM falls to the register file
	always_comb begin
		case (sel_a)
			SEL_EX_FORW: muxed_a = ex_forw;
			SEL_WB_FORW: muxed_a = wb_forw;
			default:     muxed_a = rf_dataa;
		endcase
	end

	// Operand B
	always_comb begin
		case (sel_b)
			SEL_IMM:     muxed_b = simm;
			SEL_EX_FORW: muxed_b = ex_forw;
			SEL_WB_FORW: muxed_b = wb_forw;
			default:     muxed_b = rf_datab;
		endcase
	end

	//////////////////////////////
	// Operand registers
	//////////////////////////////

	// Load on every unfrozen edge, ID never stalls without EX
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			operand_a <= '0;
			operand_b <= '0;
		end else if (!freeze) begin
			operand_a <= muxed_a;
			operand_b <= muxed_b;
		end
	end

endmodule

// File: src/exec_unit.sv
// Execute stage and WB register.
// The ALU works on the registered operands and its result feeds both
// the EX forwarding path and the WB register. The WB entry drives the
// register write and the WB forwarding path.
`timescale 1ns/1ps

module exec_unit (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         freeze,
	input  pipe_pkg::ex_ctrl_t           ex_ctrl,
	input  logic [pipe_pkg::DATA_W-1:0] operand_a,
	input  logic [pipe_pkg::DATA_W-1:0] operand_b,
	output logic [pipe_pkg::DATA_W-1:0] ex_forw,
	output pipe_pkg::wb_t                wb_st
);
	import pipe_pkg::*;

	// ALU output
	logic [DATA_W-1:0] alu_result;

	//////////////////////////////
	// ALU
	//////////////////////////////

	// Immediate forms share the base operation, B already holds simm
	always_comb begin
		case (ex_ctrl.op)
			OP_SUB:
				alu_result = operand_a - operand_b;
			OP_AND:
				alu_result = operand_a & operand_b;
			OP_OR,
			OP_ORI:
				alu_result = operand_a | operand_b;
			OP_XOR,
			OP_XORI:
				alu_result = operand_a ^ operand_b;
			// ADD, ADDI and unknown opcodes
			default:
				alu_result = operand_a + operand_b;
		endcase
	end

	// Exposed combinationally for the operand stage
	assign ex_forw = alu_result;

	//////////////////////////////
	// WB register
	//////////////////////////////

	// Under freeze EX is held, so a bubble goes to WB
	// to keep one writeback per instruction
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_st <= '0;
		end else begin
			wb_st.valid <= ex_ctrl.valid & ~freeze;
			wb_st.rd    <= ex_ctrl.rd;
			wb_st.data  <= alu_result;
		end
	end

endmodule

// File: src/pipe_top.sv
// Top level of the three-stage ID/EX/WB integer pipeline.
// Takes one instruction word per instr_valid strobe while stall is low
// and gives one wb pulse per instruction, in program order.
`timescale 1ns/1ps

module pipe_top (
	input  logic             clk,
	input  logic             arst_n,
	input  pipe_pkg::instr_u instr,
	input  logic             instr_valid,
	input  logic             stall,
	output pipe_pkg::wb_t    wb
);
	import pipe_pkg::*;

	// ID to register file and operand stage
	logic [REG_AW-1:0] ra_addr;
	logic [REG_AW-1:0] rb_addr;
	sel_e              sel_a;
	sel_e              sel_b;
	logic [DATA_W-1:0] simm;
	logic              freeze;
	ex_ctrl_t          ex_ctrl;

	// Datapath
	logic [DATA_W-1:0] rf_dataa;
	logic [DATA_W-1:0] rf_datab;
	logic [DATA_W-1:0] operand_a;
	logic [DATA_W-1:0] operand_b;
	logic [DATA_W-1:0] ex_forw;

	//////////////////////////////
	// Control
	//////////////////////////////

	pipe_ctrl i_pipe_ctrl (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr       (instr),
		.instr_valid (instr_valid),
		.stall       (stall),
		.wb_st       (wb),
		.ra_addr     (ra_addr),
		.rb_addr     (rb_addr),
		.sel_a       (sel_a),
		.sel_b       (sel_b),
		.simm        (simm),
		.freeze      (freeze),
		.ex_ctrl     (ex_ctrl)
	);

	//////////////////////////////
	// Datapath
	//////////////////////////////

	reg_file i_reg_file (
		.clk      (clk),
		.arst_n   (arst_n),
		.ra_addr  (ra_addr),
		.rb_addr  (rb_addr),
		.wb_st    (wb),
		.rf_dataa (rf_dataa),
		.rf_datab (rf_datab)
	);

	// WB forwarding taps the WB entry data
	operand_mux i_operand_mux (
		.clk       (clk),
		.arst_n    (arst_n),
		.freeze    (freeze),
		.rf_dataa  (rf_dataa),
		.rf_datab  (rf_datab),
		.ex_forw   (ex_forw),
		.wb_forw   (wb.data),
		.simm      (simm),
		.sel_a     (sel_a),
		.sel_b     (sel_b),
		.operand_a (operand_a),
		.operand_b (operand_b)
	);

	exec_unit i_exec_unit (
		.clk       (clk),
		.arst_n    (arst_n),
		.freeze    (freeze),
		.ex_ctrl   (ex_ctrl),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.ex_forw   (ex_forw),
		.wb_st     (wb)
	);

endmodule

// File: test/tb_pipe.sv
// Random-stimulus testbench for the three-stage integer pipeline.
// Drives instruction words, gaps and stall runs from a fixed seed and keeps
// an in-order register model. Every wb pulse is compared with the model's
// next expected entry. Runs until 2000 instructions have been checked.
`timescale 1ns/1ps

module tb_pipe;
	import pipe_pkg::*;

	localparam int NUM_INSTR     = 2000;
	localparam int MAX_CYCLES    = 20000;
	localparam int WB_TIMEOUT    = 30;
	localparam int DRAIN_TIMEOUT = 40;

	// DUT inputs and outputs
	logic   clk;
	logic   arst_n;
	instr_u instr;
	logic   instr_valid;
	logic   stall;
	wb_t    wb;

	// Reference model state
	logic [DATA_W-1:0] model_regs [NUM_REGS];
	wb_t               expected_q [$];
	wb_t               exp_entry;
	int                seed = 32'h3dbe_b6ac;
	int                stall_left = 0;
	int                accepted = 0;
	int                checked_count = 0;
	int                idle_cycles = 0;

	pipe_top i_pipe_top (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr       (instr),
		.instr_valid (instr_valid),
		.stall       (stall),
		.wb          (wb)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////

	function automatic logic [31:0] next_rand();
		return $random(seed);
	endfunction

	// Mostly r0..r3 so that sources often hit recent destinations
	function automatic logic [REG_AW-1:0] pick_reg();
		logic [31:0] r;
		r = next_rand();
		if (r[2:0] != 3'd0)
			return {2'b00, r[5:4]};
		else
			return r[11:8];
	endfunction

	// Opcodes 0..7 most of the time, now and then an undefined one
	function automatic logic [31:0] make_instr();
		logic [31:0] r;
		logic [3:0]  op;
		r = next_rand();
		if (r[3:0] < 4'd12)
			op = {1'b0, r[6:4]};
		else
			op = {1'b1, r[6:4]};
		return {op, pick_reg(), pick_reg(), pick_reg(), r[31:16]};
	endfunction

	// Stall runs of 1..4 cycles, always followed by a free cycle
	task automatic drive_next();
		logic [31:0] r;
		r = next_rand();
		if (stall_left != 0) begin
			stall <= 1'b1;
			stall_left--;
		end else if (!stall && r[3:0] < 4'd3) begin
			stall <= 1'b1;
			stall_left = {30'd0, r[5:4]};
		end else begin
			stall <= 1'b0;
		end
		instr_valid <= (r[9:7] != 3'd0);
		instr <= make_instr();
	endtask

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic logic is_imm_op(input logic [3:0] op);
		return (op == OP_ADDI) || (op == OP_ORI) || (op == OP_XORI);
	endfunction

	// Immediate forms share the register form's operation
	function automatic logic [DATA_W-1:0] alu_model(
		input logic [3:0]        op,
		input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b
	);
		logic [DATA_W-1:0] res;
		res = a + b;
		if (op == OP_SUB)
			res = a - b;
		else if (op == OP_AND)
			res = a & b;
		else if ((op == OP_OR) || (op == OP_ORI))
			res = a | b;
		else if ((op == OP_XOR) || (op == OP_XORI))
			res = a ^ b;
		return res;
	endfunction

	// Word layout: op[31:28] rd[27:24] ra[23:20] rb[19:16] imm[15:0]
	task automatic model_accept(input logic [31:0] word);
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		wb_t               entry;
		a = model_regs[word[23:20]];
		if (is_imm_op(word[31:28]))
			b = {{(DATA_W-IMM_W){word[15]}}, word[15:0]};
		else
			b = model_regs[word[19:16]];
		entry.valid = 1'b1;
		entry.rd    = word[27:24];
		entry.data  = alu_model(word[31:28], a, b);
		model_regs[entry.rd] = entry.data;
		expected_q.push_back(entry);
	endtask

	//////////////////////////////
	// Checks
	//////////////////////////////

	task automatic check_value(
		input string             name,
		input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp
	);
		if (got !== exp) begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1, "Value mismatch");
		end
	endtask

	task automatic abort_run(input string reason);
		$display("Error: %s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped on error");
	endtask

	// wb is stable at the falling edge, one sample per pulse
	always @(negedge clk) begin
		if (wb.valid) begin
			if (expected_q.size() == 0) begin
				abort_run("writeback pulse with no accepted instruction outstanding");
			end else begin
				exp_entry = expected_q.pop_front();
				check_value("wb.rd", {{(DATA_W-REG_AW){1'b0}}, wb.rd},
					{{(DATA_W-REG_AW){1'b0}}, exp_entry.rd});
				check_value("wb.data", wb.data, exp_entry.data);
				checked_count++;
				idle_cycles = 0;
			end
		end else if (expected_q.size() != 0) begin
			idle_cycles++;
			if (idle_cycles > WB_TIMEOUT)
				abort_run("no writeback arrived for an accepted instruction");
		end else begin
			idle_cycles = 0;
		end
	end

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		int cycles;
		int waited;
		arst_n      <= 1'b0;
		instr       <= '0;
		instr_valid <= 1'b0;
		stall       <= 1'b0;
		for (int i = 0; i < NUM_REGS; i++)
			model_regs[i] = '0;

		repeat (5) @(posedge clk);
		arst_n <= 1'b1;
		// Quiet cycles, the monitor flags any early wb pulse
		repeat (3) @(posedge clk);

		// Accept on each edge that sees instr_valid high and stall low
		cycles = 0;
		while (accepted < NUM_INSTR && cycles < MAX_CYCLES) begin
			drive_next();
			@(posedge clk);
			cycles++;
			if (instr_valid && !stall) begin
				model_accept(instr);
				accepted++;
			end
		end
		instr_valid <= 1'b0;
		stall       <= 1'b0;
		if (accepted != NUM_INSTR)
			abort_run("stimulus did not reach the instruction count in time");

		// Drain the pipeline
		waited = 0;
		while (expected_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (expected_q.size() != 0)
			abort_run("no writeback arrived for the last instructions");

		// Idle tail to catch extra pulses
		repeat (10) @(negedge clk);

		if (expected_q.size() == 0 && checked_count == NUM_INSTR) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			abort_run("writeback count differs from the accepted instruction count");
		end
	end

endmodule

// File: all.f
src/pipe_pkg.sv
src/pipe_ctrl.sv
src/reg_file.sv
src/operand_mux.sv
src/exec_unit.sv
src/pipe_top.sv
test/tb_pipe.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module tb_pipe -f all.f

sim_out=$(./obj_dir/Vtb_pipe 2>&1 || true)
echo "$sim_out"

if grep -qF '*** TEST PASSED ***' <<< "$sim_out"; then
	exit 0
fi
exit 1
